//--- src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int ISA_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int SHAMT_WIDTH    = 5;

    typedef logic [ISA_WIDTH-1:0]      word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_idx_t;

    // major opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    // r-type function, instr[5:0]
    typedef enum logic [5:0] {
        F_SLL = 6'd0,
        F_SRL = 6'd2,
        F_ADD = 6'd32,
        F_SUB = 6'd34,
        F_AND = 6'd36,
        F_OR  = 6'd37,
        F_XOR = 6'd38,
        F_SLT = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // where an EX operand comes from
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- src/instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder (
    input  mips_pkg::word_t    instr,
    output mips_pkg::alu_op_e  alu_op,
    output logic               use_imm,
    output logic               use_shamt,
    output logic               reg_write,
    output logic               mem_read,
    output logic               mem_write,
    output logic               is_branch,
    output logic               branch_on_equal,
    output logic               is_jump,
    output mips_pkg::reg_idx_t dest_idx,
    output mips_pkg::word_t    imm_ext
);
    import mips_pkg::*;

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    always_comb begin
        alu_op          = ALU_ADD;
        use_imm         = 1'b0;
        use_shamt       = 1'b0;
        reg_write       = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        is_branch       = 1'b0;
        branch_on_equal = 1'b0;
        is_jump         = 1'b0;
        dest_idx        = instr[20:16];
        imm_ext         = {{(ISA_WIDTH-16){instr[15]}}, instr[15:0]};

        case (opcode)
            OP_RTYPE: begin
                dest_idx  = instr[15:11];
                reg_write = 1'b1;
                case (funct)
                    F_ADD: alu_op = ALU_ADD;
                    F_SUB: alu_op = ALU_SUB;
                    F_AND: alu_op = ALU_AND;
                    F_OR:  alu_op = ALU_OR;
                    F_XOR: alu_op = ALU_XOR;
                    F_SLT: alu_op = ALU_SLT;
                    F_SLL: begin
                        alu_op    = ALU_SLL;
                        use_shamt = 1'b1;
                    end
                    F_SRL: begin
                        alu_op    = ALU_SRL;
                        use_shamt = 1'b1;
                    end
                    // unsupported funct acts as a no-op
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDI: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SW: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ: begin
                alu_op          = ALU_SUB;
                is_branch       = 1'b1;
                branch_on_equal = 1'b1;
            end
            OP_BNE: begin
                alu_op    = ALU_SUB;
                is_branch = 1'b1;
            end
            OP_J: begin
                is_jump = 1'b1;
                // word target, upper pc bits added in EX
                imm_ext = {{(ISA_WIDTH-28){1'b0}}, instr[25:0], 2'b00};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    input  logic               wr_en,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data
);
    import mips_pkg::*;

    word_t regs [2**REG_ADDR_WIDTH];
    logic  wr_live;

    // r0 is never written
    assign wr_live = wr_en && (wr_idx != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-first bypass for a WB write in the same cycle
    assign rs_data = (wr_live && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
    assign rt_data = (wr_live && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule

`default_nettype wire

//--- src/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  mips_pkg::reg_idx_t id_rs_idx,
    input  mips_pkg::reg_idx_t id_rt_idx,
    input  mips_pkg::reg_idx_t ex_rs_idx,
    input  mips_pkg::reg_idx_t ex_rt_idx,
    input  mips_pkg::reg_idx_t ex_dest_idx,
    input  logic               ex_mem_read,
    input  logic               ex_valid,
    input  mips_pkg::reg_idx_t mem_dest_idx,
    input  logic               mem_reg_write,
    input  logic               mem_valid,
    input  mips_pkg::reg_idx_t wb_dest_idx,
    input  logic               wb_reg_write,
    input  logic               wb_valid,
    input  logic               branch_taken,
    output mips_pkg::fwd_sel_e fwd_a,
    output mips_pkg::fwd_sel_e fwd_b,
    output logic               stall,
    output logic               flush
);
    import mips_pkg::*;

    logic mem_writes;
    logic wb_writes;
    logic load_use;

    assign mem_writes = mem_valid && mem_reg_write && (mem_dest_idx != '0);
    assign wb_writes  = wb_valid && wb_reg_write && (wb_dest_idx != '0);

    // younger result in MEM wins over WB
    function automatic fwd_sel_e pick_source(input reg_idx_t src);
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (mem_writes && mem_dest_idx == src) begin
            sel = FWD_MEM;
        end else if (wb_writes && wb_dest_idx == src) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_source(ex_rs_idx);
        fwd_b = pick_source(ex_rt_idx);
    end

    assign load_use = ex_valid && ex_mem_read && (ex_dest_idx != '0)
                    && (ex_dest_idx == id_rs_idx || ex_dest_idx == id_rt_idx);

    assign flush = branch_taken;
    assign stall = load_use && !branch_taken;

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  mips_pkg::word_t                    pc,
    input  mips_pkg::word_t                    rs_data,
    input  mips_pkg::word_t                    rt_data,
    input  mips_pkg::word_t                    imm_ext,
    input  logic [mips_pkg::SHAMT_WIDTH-1:0]   shamt,
    input  mips_pkg::alu_op_e                  alu_op,
    input  logic                               use_imm,
    input  logic                               use_shamt,
    input  logic                               is_branch,
    input  logic                               branch_on_equal,
    input  logic                               is_jump,
    input  logic                               valid,
    input  mips_pkg::fwd_sel_e                 fwd_a,
    input  mips_pkg::fwd_sel_e                 fwd_b,
    input  mips_pkg::word_t                    mem_result,
    input  mips_pkg::word_t                    wb_result,
    output mips_pkg::word_t                    alu_result,
    output mips_pkg::word_t                    store_value,
    output logic                               branch_taken,
    output mips_pkg::word_t                    branch_target
);
    import mips_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t src_a;
    word_t src_b;
    word_t pc_plus4;
    logic  operands_equal;

    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = mem_result;
            FWD_WB:  op_a = wb_result;
            default: op_a = rs_data;
        endcase
        case (fwd_b)
            FWD_MEM: op_b = mem_result;
            FWD_WB:  op_b = wb_result;
            default: op_b = rt_data;
        endcase
    end

    // shifts move rt by the shamt field
    assign src_a = use_shamt ? op_b : op_a;
    assign src_b = use_shamt ? word_t'(shamt) : (use_imm ? imm_ext : op_b);

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = src_a + src_b;
            ALU_SUB: alu_result = src_a - src_b;
            ALU_AND: alu_result = src_a & src_b;
            ALU_OR:  alu_result = src_a | src_b;
            ALU_XOR: alu_result = src_a ^ src_b;
            ALU_SLT: alu_result = word_t'($signed(src_a) < $signed(src_b));
            ALU_SLL: alu_result = src_a << src_b[SHAMT_WIDTH-1:0];
            ALU_SRL: alu_result = src_a >> src_b[SHAMT_WIDTH-1:0];
            default: alu_result = '0;
        endcase
    end

    assign store_value = op_b;

    assign operands_equal = (op_a == op_b);
    assign branch_taken   = valid
                          && (is_jump || (is_branch && (operands_equal == branch_on_equal)));

    assign pc_plus4 = pc + word_t'(4);

    // jump keeps the top nibble of pc+4
    assign branch_target = is_jump
                         ? {pc_plus4[ISA_WIDTH-1:28], imm_ext[27:0]}
                         : pc_plus4 + {imm_ext[ISA_WIDTH-3:0], 2'b00};

endmodule

`default_nettype wire

//--- src/pipeline_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu #(
    parameter int IMEM_ADDR_WIDTH = 8,
    parameter int DMEM_ADDR_WIDTH = 8
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       run,
    input  logic                       prog_we,
    input  logic [IMEM_ADDR_WIDTH-1:0] prog_addr,
    input  mips_pkg::word_t            prog_data,
    output logic                       store_valid,
    output mips_pkg::word_t            store_addr,
    output mips_pkg::word_t            store_data
);
    import mips_pkg::*;

    word_t imem [2**IMEM_ADDR_WIDTH];
    word_t dmem [2**DMEM_ADDR_WIDTH];

    // IF
    word_t pc;
    word_t if_instr;

    // IF/ID
    logic  if_id_valid;
    word_t if_id_instr;
    word_t if_id_pc;

    // decode and register file outputs
    alu_op_e  id_alu_op;
    logic     id_use_imm;
    logic     id_use_shamt;
    logic     id_reg_write;
    logic     id_mem_read;
    logic     id_mem_write;
    logic     id_is_branch;
    logic     id_branch_on_equal;
    logic     id_is_jump;
    reg_idx_t id_dest_idx;
    word_t    id_imm_ext;
    word_t    id_rs_data;
    word_t    id_rt_data;

    // ID/EX
    logic                   id_ex_valid;
    word_t                  id_ex_pc;
    word_t                  id_ex_rs_data;
    word_t                  id_ex_rt_data;
    word_t                  id_ex_imm_ext;
    logic [SHAMT_WIDTH-1:0] id_ex_shamt;
    alu_op_e                id_ex_alu_op;
    logic                   id_ex_use_imm;
    logic                   id_ex_use_shamt;
    logic                   id_ex_reg_write;
    logic                   id_ex_mem_read;
    logic                   id_ex_mem_write;
    logic                   id_ex_is_branch;
    logic                   id_ex_branch_on_equal;
    logic                   id_ex_is_jump;
    reg_idx_t               id_ex_dest_idx;
    reg_idx_t               id_ex_rs_idx;
    reg_idx_t               id_ex_rt_idx;

    // EX outputs and hazard control
    word_t    ex_alu_result;
    word_t    ex_store_value;
    logic     branch_taken;
    word_t    branch_target;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     stall;
    logic     flush;

    // EX/MEM
    logic     ex_mem_valid;
    word_t    ex_mem_alu_result;
    word_t    ex_mem_store_value;
    logic     ex_mem_reg_write;
    logic     ex_mem_mem_read;
    logic     ex_mem_mem_write;
    reg_idx_t ex_mem_dest_idx;
    word_t    mem_load_data;

    // MEM/WB
    logic     mem_wb_valid;
    word_t    mem_wb_alu_result;
    word_t    mem_wb_load_data;
    logic     mem_wb_reg_write;
    logic     mem_wb_mem_read;
    reg_idx_t mem_wb_dest_idx;
    word_t    wb_result;

    // program port, only while halted
    always_ff @(posedge clk) begin
        if (prog_we && !run) begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign if_instr = imem[pc[IMEM_ADDR_WIDTH+1:2]];

    // pc and stage valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= '0;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end else if (!run) begin
            pc           <= '0;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end else begin
            if (flush) begin
                pc          <= branch_target;
                if_id_valid <= 1'b0;
            end else if (!stall) begin
                pc          <= pc + word_t'(4);
                if_id_valid <= 1'b1;
            end
            id_ex_valid  <= if_id_valid && !flush && !stall;
            ex_mem_valid <= id_ex_valid;
            mem_wb_valid <= ex_mem_valid;
        end
    end

    instruction_decoder instruction_decoder_inst (
        .instr           (if_id_instr),
        .alu_op          (id_alu_op),
        .use_imm         (id_use_imm),
        .use_shamt       (id_use_shamt),
        .reg_write       (id_reg_write),
        .mem_read        (id_mem_read),
        .mem_write       (id_mem_write),
        .is_branch       (id_is_branch),
        .branch_on_equal (id_branch_on_equal),
        .is_jump         (id_is_jump),
        .dest_idx        (id_dest_idx),
        .imm_ext         (id_imm_ext)
    );

    register_file register_file_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (if_id_instr[25:21]),
        .rt_idx  (if_id_instr[20:16]),
        .rs_data (id_rs_data),
        .rt_data (id_rt_data),
        .wr_en   (mem_wb_valid && mem_wb_reg_write),
        .wr_idx  (mem_wb_dest_idx),
        .wr_data (wb_result)
    );

    hazard_unit hazard_unit_inst (
        .id_rs_idx     (if_id_instr[25:21]),
        .id_rt_idx     (if_id_instr[20:16]),
        .ex_rs_idx     (id_ex_rs_idx),
        .ex_rt_idx     (id_ex_rt_idx),
        .ex_dest_idx   (id_ex_dest_idx),
        .ex_mem_read   (id_ex_mem_read),
        .ex_valid      (id_ex_valid),
        .mem_dest_idx  (ex_mem_dest_idx),
        .mem_reg_write (ex_mem_reg_write),
        .mem_valid     (ex_mem_valid),
        .wb_dest_idx   (mem_wb_dest_idx),
        .wb_reg_write  (mem_wb_reg_write),
        .wb_valid      (mem_wb_valid),
        .branch_taken  (branch_taken),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .stall         (stall),
        .flush         (flush)
    );

    execute_stage execute_stage_inst (
        .pc              (id_ex_pc),
        .rs_data         (id_ex_rs_data),
        .rt_data         (id_ex_rt_data),
        .imm_ext         (id_ex_imm_ext),
        .shamt           (id_ex_shamt),
        .alu_op          (id_ex_alu_op),
        .use_imm         (id_ex_use_imm),
        .use_shamt       (id_ex_use_shamt),
        .is_branch       (id_ex_is_branch),
        .branch_on_equal (id_ex_branch_on_equal),
        .is_jump         (id_ex_is_jump),
        .valid           (id_ex_valid),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b),
        .mem_result      (ex_mem_alu_result),
        .wb_result       (wb_result),
        .alu_result      (ex_alu_result),
        .store_value     (ex_store_value),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target)
    );

    // stage payloads, qualified by the valid bits
    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_instr <= if_instr;
            if_id_pc    <= pc;
        end
        id_ex_pc              <= if_id_pc;
        id_ex_rs_data         <= id_rs_data;
        id_ex_rt_data         <= id_rt_data;
        id_ex_imm_ext         <= id_imm_ext;
        id_ex_shamt           <= if_id_instr[10:6];
        id_ex_alu_op          <= id_alu_op;
        id_ex_use_imm         <= id_use_imm;
        id_ex_use_shamt       <= id_use_shamt;
        id_ex_reg_write       <= id_reg_write;
        id_ex_mem_read        <= id_mem_read;
        id_ex_mem_write       <= id_mem_write;
        id_ex_is_branch       <= id_is_branch;
        id_ex_branch_on_equal <= id_branch_on_equal;
        id_ex_is_jump         <= id_is_jump;
        id_ex_dest_idx        <= id_dest_idx;
        id_ex_rs_idx          <= if_id_instr[25:21];
        id_ex_rt_idx          <= if_id_instr[20:16];

        ex_mem_alu_result  <= ex_alu_result;
        ex_mem_store_value <= ex_store_value;
        ex_mem_reg_write   <= id_ex_reg_write;
        ex_mem_mem_read    <= id_ex_mem_read;
        ex_mem_mem_write   <= id_ex_mem_write;
        ex_mem_dest_idx    <= id_ex_dest_idx;

        mem_wb_alu_result <= ex_mem_alu_result;
        mem_wb_load_data  <= mem_load_data;
        mem_wb_reg_write  <= ex_mem_reg_write;
        mem_wb_mem_read   <= ex_mem_mem_read;
        mem_wb_dest_idx   <= ex_mem_dest_idx;
    end

    // data memory, word addressed
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**DMEM_ADDR_WIDTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_valid) begin
            dmem[ex_mem_alu_result[DMEM_ADDR_WIDTH+1:2]] <= ex_mem_store_value;
        end
    end

    assign mem_load_data = dmem[ex_mem_alu_result[DMEM_ADDR_WIDTH+1:2]];

    assign store_valid = ex_mem_valid && ex_mem_mem_write;
    assign store_addr  = ex_mem_alu_result;
    assign store_data  = ex_mem_store_value;

    assign wb_result = mem_wb_mem_read ? mem_wb_load_data : mem_wb_alu_result;

endmodule

`default_nettype wire

//--- verif/pipeline_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu_tb;
    import mips_pkg::*;

    localparam int IMEM_AW        = 8;
    localparam int DMEM_AW        = 8;
    localparam int NUM_PROGS      = 8;
    localparam int PROG_WORDS     = 16;
    // extra zero words keep fetches past the last jump clean
    localparam int LOAD_WORDS     = 32;
    localparam int MAX_STORES     = 8;
    localparam int QUIET_CYCLES   = 20;
    localparam int TIMEOUT_CYCLES = 200 * NUM_PROGS;

    logic               clk;
    logic               arst_n;
    logic               run;
    logic               prog_we;
    logic [IMEM_AW-1:0] prog_addr;
    word_t              prog_data;
    logic               store_valid;
    word_t              store_addr;
    word_t              store_data;

    // program table and expected store streams
    word_t prog_mem [NUM_PROGS][PROG_WORDS];
    int    prog_len [NUM_PROGS];
    word_t exp_addr [NUM_PROGS][MAX_STORES];
    word_t exp_data [NUM_PROGS][MAX_STORES];
    int    exp_count [NUM_PROGS];

    int mismatch_errors = 0;
    int held_errors     = 0;
    int extra_errors    = 0;
    int cycle_count     = 0;

    pipeline_cpu #(
        .IMEM_ADDR_WIDTH (IMEM_AW),
        .DMEM_ADDR_WIDTH (DMEM_AW)
    ) pipeline_cpu_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the store stream did not complete within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("errors: %0d wrong stores, %0d stores while held, %0d extra stores",
                     mismatch_errors, held_errors, extra_errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // field order follows the encoding, msb first
    function automatic word_t rtype_word(input funct_e funct, input int rs, input int rt,
                                         input int rd, input int shamt);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
    endfunction

    function automatic word_t itype_word(input opcode_e op, input int rs, input int rt,
                                         input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t jump_word(input int target);
        return {OP_J, target[25:0]};
    endfunction

    task automatic add_instr(input int p, input word_t w);
        prog_mem[p][prog_len[p]] = w;
        prog_len[p] = prog_len[p] + 1;
    endtask

    task automatic expect_store(input int p, input word_t addr, input word_t data);
        exp_addr[p][exp_count[p]] = addr;
        exp_data[p][exp_count[p]] = data;
        exp_count[p] = exp_count[p] + 1;
    endtask

    task automatic build_table();
        for (int p = 0; p < NUM_PROGS; p++) begin
            prog_len[p]  = 0;
            exp_count[p] = 0;
            for (int w = 0; w < PROG_WORDS; w++) begin
                prog_mem[p][w] = '0;
            end
        end

        // alu ops on 12 and -5
        add_instr(0, itype_word(OP_ADDI, 0, 1, 12));
        add_instr(0, itype_word(OP_ADDI, 0, 2, -5));
        add_instr(0, rtype_word(F_ADD, 1, 2, 3, 0));
        add_instr(0, itype_word(OP_SW, 0, 3, 0));
        add_instr(0, rtype_word(F_SUB, 2, 1, 4, 0));
        add_instr(0, itype_word(OP_SW, 0, 4, 4));
        add_instr(0, rtype_word(F_AND, 1, 2, 5, 0));
        add_instr(0, itype_word(OP_SW, 0, 5, 8));
        add_instr(0, rtype_word(F_OR, 1, 2, 6, 0));
        add_instr(0, itype_word(OP_SW, 0, 6, 12));
        add_instr(0, rtype_word(F_XOR, 1, 2, 7, 0));
        add_instr(0, itype_word(OP_SW, 0, 7, 16));
        add_instr(0, rtype_word(F_SLT, 2, 1, 8, 0));
        add_instr(0, itype_word(OP_SW, 0, 8, 20));
        add_instr(0, jump_word(14));
        expect_store(0, 0, 7);
        expect_store(0, 4, 32'hffff_ffef);
        expect_store(0, 8, 8);
        expect_store(0, 12, 32'hffff_ffff);
        expect_store(0, 16, 32'hffff_fff7);
        expect_store(0, 20, 1);

        // shifts, signed slt, negative immediates and offsets
        add_instr(1, itype_word(OP_ADDI, 0, 1, -8));
        add_instr(1, itype_word(OP_ADDI, 0, 2, 3));
        add_instr(1, rtype_word(F_SLL, 0, 1, 3, 4));
        add_instr(1, itype_word(OP_SW, 0, 3, 32));
        add_instr(1, rtype_word(F_SRL, 0, 1, 4, 28));
        add_instr(1, itype_word(OP_SW, 0, 4, 36));
        add_instr(1, rtype_word(F_SLT, 2, 1, 5, 0));
        add_instr(1, itype_word(OP_SW, 0, 5, 40));
        add_instr(1, itype_word(OP_ADDI, 1, 6, -100));
        add_instr(1, itype_word(OP_ADDI, 0, 7, 60));
        add_instr(1, itype_word(OP_SW, 7, 6, -12));
        add_instr(1, jump_word(11));
        expect_store(1, 32, 32'hffff_ff80);
        expect_store(1, 36, 32'h0000_000f);
        expect_store(1, 40, 0);
        expect_store(1, 48, 32'hffff_ff94);

        // dependent chain, values from MEM and WB
        add_instr(2, itype_word(OP_ADDI, 0, 1, 5));
        add_instr(2, itype_word(OP_ADDI, 1, 2, 3));
        add_instr(2, rtype_word(F_ADD, 2, 1, 3, 0));
        add_instr(2, rtype_word(F_SUB, 3, 2, 4, 0));
        add_instr(2, itype_word(OP_SW, 0, 4, 0));
        add_instr(2, rtype_word(F_ADD, 4, 3, 5, 0));
        add_instr(2, itype_word(OP_SW, 0, 5, 4));
        add_instr(2, itype_word(OP_ADDI, 0, 6, 100));
        add_instr(2, itype_word(OP_SW, 0, 6, 8));
        add_instr(2, itype_word(OP_ADDI, 0, 7, 16));
        add_instr(2, '0);
        add_instr(2, itype_word(OP_SW, 7, 1, 0));
        add_instr(2, jump_word(12));
        expect_store(2, 0, 5);
        expect_store(2, 4, 18);
        expect_store(2, 8, 100);
        expect_store(2, 16, 5);

        // loads feeding the very next instruction
        add_instr(3, itype_word(OP_ADDI, 0, 1, 77));
        add_instr(3, itype_word(OP_SW, 0, 1, 64));
        add_instr(3, itype_word(OP_LW, 0, 2, 64));
        add_instr(3, rtype_word(F_ADD, 2, 1, 3, 0));
        add_instr(3, itype_word(OP_SW, 0, 3, 68));
        add_instr(3, itype_word(OP_LW, 0, 4, 68));
        add_instr(3, itype_word(OP_SW, 0, 4, 72));
        add_instr(3, itype_word(OP_ADDI, 0, 5, -1));
        add_instr(3, itype_word(OP_SW, 0, 5, 76));
        add_instr(3, itype_word(OP_LW, 0, 6, 76));
        add_instr(3, rtype_word(F_SUB, 0, 6, 7, 0));
        add_instr(3, itype_word(OP_SW, 0, 7, 80));
        add_instr(3, jump_word(12));
        expect_store(3, 64, 77);
        expect_store(3, 68, 154);
        expect_store(3, 72, 154);
        expect_store(3, 76, 32'hffff_ffff);
        expect_store(3, 80, 1);

        // stores in the shadow of a taken branch or jump must vanish
        add_instr(4, itype_word(OP_ADDI, 0, 1, 3));
        add_instr(4, itype_word(OP_ADDI, 0, 2, 3));
        add_instr(4, itype_word(OP_BEQ, 1, 2, 2));
        add_instr(4, itype_word(OP_SW, 0, 1, 0));
        add_instr(4, itype_word(OP_SW, 0, 2, 4));
        add_instr(4, itype_word(OP_BNE, 1, 2, 2));
        add_instr(4, itype_word(OP_SW, 0, 1, 8));
        add_instr(4, itype_word(OP_BEQ, 1, 0, 5));
        add_instr(4, itype_word(OP_BNE, 1, 0, 2));
        add_instr(4, itype_word(OP_SW, 0, 1, 12));
        add_instr(4, itype_word(OP_SW, 0, 1, 16));
        add_instr(4, jump_word(14));
        add_instr(4, itype_word(OP_SW, 0, 1, 20));
        add_instr(4, itype_word(OP_SW, 0, 1, 24));
        add_instr(4, itype_word(OP_SW, 0, 2, 28));
        add_instr(4, jump_word(15));
        expect_store(4, 8, 3);
        expect_store(4, 28, 3);

        // bne loop, four passes
        add_instr(5, itype_word(OP_ADDI, 0, 1, 0));
        add_instr(5, itype_word(OP_ADDI, 0, 2, 4));
        add_instr(5, itype_word(OP_ADDI, 0, 3, 256));
        add_instr(5, itype_word(OP_ADDI, 1, 1, 1));
        add_instr(5, itype_word(OP_SW, 3, 1, 0));
        add_instr(5, itype_word(OP_ADDI, 3, 3, 4));
        add_instr(5, itype_word(OP_BNE, 1, 2, -4));
        add_instr(5, itype_word(OP_SW, 0, 3, 0));
        add_instr(5, jump_word(8));
        for (int k = 0; k < 4; k++) begin
            expect_store(5, 256 + 4 * k, k + 1);
        end
        expect_store(5, 0, 272);

        // writes to r0 are dropped
        add_instr(6, itype_word(OP_ADDI, 0, 0, 55));
        add_instr(6, rtype_word(F_ADD, 0, 0, 1, 0));
        add_instr(6, itype_word(OP_ADDI, 0, 2, 9));
        add_instr(6, itype_word(OP_SW, 0, 1, 4));
        add_instr(6, rtype_word(F_ADD, 0, 2, 3, 0));
        add_instr(6, itype_word(OP_SW, 0, 3, 8));
        add_instr(6, itype_word(OP_ADDI, 0, 0, 77));
        add_instr(6, itype_word(OP_SW, 0, 0, 12));
        add_instr(6, jump_word(8));
        expect_store(6, 4, 0);
        expect_store(6, 8, 9);
        expect_store(6, 12, 0);

        // rerun of the forwarding program
        for (int w = 0; w < prog_len[2]; w++) begin
            add_instr(7, prog_mem[2][w]);
        end
        for (int k = 0; k < exp_count[2]; k++) begin
            expect_store(7, exp_addr[2][k], exp_data[2][k]);
        end
    endtask

    task automatic check_held(input int p);
        @(negedge clk);
        assert (!store_valid) else begin
            held_errors++;
            $display("[ERROR] %0t: program %0d store_valid high while the core was held",
                     $time, p);
        end
    endtask

    task automatic reset_core(input int p);
        @(posedge clk);
        #2;
        arst_n  = 1'b0;
        run     = 1'b0;
        prog_we = 1'b0;
        repeat (5) begin
            check_held(p);
        end
        @(posedge clk);
        #2;
        arst_n = 1'b1;
    endtask

    task automatic load_program(input int p);
        for (int w = 0; w < LOAD_WORDS; w++) begin
            @(posedge clk);
            #2;
            prog_we   = 1'b1;
            prog_addr = IMEM_AW'(w);
            prog_data = (w < PROG_WORDS) ? prog_mem[p][w] : '0;
            check_held(p);
        end
        @(posedge clk);
        #2;
        prog_we = 1'b0;
        run     = 1'b1;
    endtask

    task automatic check_stores(input int p);
        int seen;
        seen = 0;
        while (seen < exp_count[p]) begin
            @(negedge clk);
            if (store_valid) begin
                assert (store_addr == exp_addr[p][seen] && store_data == exp_data[p][seen])
                else begin
                    mismatch_errors++;
                    $display("[ERROR] %0t: program %0d store %0d expected %h:%h got %h:%h",
                             $time, p, seen, exp_addr[p][seen], exp_data[p][seen],
                             store_addr, store_data);
                end
                seen++;
            end
        end
        // the program spins on its final jump from here on
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (!store_valid) else begin
                extra_errors++;
                $display("program %0d wrote an unexpected extra store to address %h",
                         p, store_addr);
            end
        end
        @(posedge clk);
        #2;
        run = 1'b0;
    endtask

    initial begin
        arst_n    = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_table();

        for (int p = 0; p < NUM_PROGS; p++) begin
            reset_core(p);
            load_program(p);
            check_stores(p);
        end

        $display("errors: %0d wrong stores, %0d stores while held, %0d extra stores",
                 mismatch_errors, held_errors, extra_errors);
        if (mismatch_errors + held_errors + extra_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/mips_pkg.sv
src/instruction_decoder.sv
src/register_file.sv
src/hazard_unit.sv
src/execute_stage.sv
src/pipeline_cpu.sv
verif/pipeline_cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= pipeline_cpu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
